//--- rtl/dcache_settings.svh
// data cache geometry and memory credit count, included by the packages and the RTL
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address width
`define DCACHE_ADDR_W 32

// width of one CPU word
`define DCACHE_WORD_W 32

// one cache line, four words
`define DCACHE_LINE_W 128

// associativity and sets per way
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// requests the memory side can take before it returns a credit
`define DCACHE_MEM_CREDITS 2

`endif

//--- rtl/dcache_addr_pkg.sv
// address field types and helpers for the data cache, imported by the bus package and the RTL
`include "dcache_settings.svh"

package dcache_addr_pkg;

    localparam int unsigned WORDS_PER_LINE = `DCACHE_LINE_W / `DCACHE_WORD_W;
    localparam int unsigned BYTE_OFF_W = $clog2(`DCACHE_WORD_W / 8);
    localparam int unsigned WORD_OFF_W = $clog2(WORDS_PER_LINE);
    localparam int unsigned LINE_OFF_W = BYTE_OFF_W + WORD_OFF_W;
    localparam int unsigned INDEX_W = $clog2(`DCACHE_SETS);
    localparam int unsigned TAG_W = `DCACHE_ADDR_W - INDEX_W - LINE_OFF_W;

    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_OFF_W-1:0] offset_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [`DCACHE_WAYS-1:0] way_sel_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_idx_t;

    // line address, tag on top
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } label_t;

    function automatic tag_t get_tag(addr_t addr);
        return addr[`DCACHE_ADDR_W-1 -: TAG_W];
    endfunction

    function automatic index_t get_index(addr_t addr);
        return addr[LINE_OFF_W +: INDEX_W];
    endfunction

    function automatic offset_t get_offset(addr_t addr);
        return addr[BYTE_OFF_W +: WORD_OFF_W];
    endfunction

    function automatic label_t get_label(addr_t addr);
        return addr[`DCACHE_ADDR_W-1 -: TAG_W + INDEX_W];
    endfunction

endpackage

//--- rtl/dcache_bus_pkg.sv
// request, response and tag entry structs of the CPU and memory ports, imported by the RTL
`include "dcache_settings.svh"

package dcache_bus_pkg;

    import dcache_addr_pkg::*;

    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] be_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        word_t wdata;
        be_t   be;
    } cpu_req_t;

    typedef struct packed {
        logic  valid;
        word_t rdata;
    } cpu_resp_t;

    // writeback carries data, refill only the label
    typedef struct packed {
        logic   valid;
        logic   write;
        label_t label;
        line_t  data;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        line_t data;
    } mem_resp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

//--- rtl/dcache_lookup.sv
// lookup stage of the data cache, holds the accepted request and picks the array read index
`include "dcache_settings.svh"

module dcache_lookup (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_bus_pkg::cpu_req_t cpu_req_i,
    input  logic                     ready_i,
    output dcache_addr_pkg::index_t  rd_index_o,
    output dcache_bus_pkg::cpu_req_t stage_req_o
);

    import dcache_addr_pkg::*;

    // stalled: keep reading the set of the held request
    assign rd_index_o = ready_i ? get_index(cpu_req_i.addr) : get_index(stage_req_o.addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_req_o.valid <= 1'b0;
        end else if (ready_i) begin
            // valid low here when nothing was accepted
            stage_req_o <= cpu_req_i;
        end
    end

endmodule

//--- rtl/dcache_way.sv
// one way of the data cache, tag and line arrays with read-first sync read and tag compare
`include "dcache_settings.svh"

module dcache_way (
    input  logic                       clk,
    input  dcache_addr_pkg::index_t    rd_index_i,
    input  dcache_addr_pkg::tag_t      lookup_tag_i,
    input  logic                       we_i,
    input  dcache_addr_pkg::index_t    wr_index_i,
    input  dcache_bus_pkg::tag_entry_t wr_entry_i,
    input  dcache_bus_pkg::line_t      wr_line_i,
    output logic                       hit_o,
    output dcache_bus_pkg::tag_entry_t entry_o,
    output dcache_bus_pkg::line_t      line_o
);

    import dcache_bus_pkg::*;

    tag_entry_t tag_mem [`DCACHE_SETS];
    line_t      line_mem [`DCACHE_SETS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_mem[wr_index_i]  <= wr_entry_i;
            line_mem[wr_index_i] <= wr_line_i;
        end
    end

    // a write to the same set shows up one cycle later
    always_ff @(posedge clk) begin
        entry_o <= tag_mem[rd_index_i];
        line_o  <= line_mem[rd_index_i];
    end

    assign hit_o = entry_o.valid && (entry_o.tag == lookup_tag_i);

endmodule

//--- rtl/dcache_plru.sv
// tree pseudo-LRU state of every set with victim lookup, used by the cache controller
`include "dcache_settings.svh"

module dcache_plru (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_addr_pkg::index_t   index_i,
    input  logic                      update_i,
    input  dcache_addr_pkg::way_sel_t access_i,
    output dcache_addr_pkg::way_idx_t victim_o
);

    import dcache_addr_pkg::*;

    localparam int unsigned TREE_W = `DCACHE_WAYS - 1;

    // bit 0 picks the half, bit 1 the way in ways 0-1, bit 2 the way in ways 2-3
    logic [`DCACHE_SETS-1:0][TREE_W-1:0] tree_q;
    logic [TREE_W-1:0] tree_cur;
    way_idx_t acc_way;

    always_comb begin
        acc_way = '0;
        for (int i = 0; i < `DCACHE_WAYS; i++) begin
            if (access_i[i]) begin
                acc_way = way_idx_t'(i);
            end
        end
    end

    assign tree_cur = tree_q[index_i];
    assign victim_o = {tree_cur[0], tree_cur[0] ? tree_cur[2] : tree_cur[1]};

    // point every level on the path away from the accessed way
    always_ff @(posedge clk) begin
        if (rst) begin
            tree_q <= '0;
        end else if (update_i) begin
            tree_q[index_i][0] <= ~acc_way[1];
            if (acc_way[1]) begin
                tree_q[index_i][2] <= ~acc_way[0];
            end else begin
                tree_q[index_i][1] <= ~acc_way[0];
            end
        end
    end

endmodule

//--- rtl/dcache_ctrl.sv
// data cache controller with hit path, forwarding, write merge, miss FSM and memory credits
`include "dcache_settings.svh"

module dcache_ctrl (
    input  logic                                          clk,
    input  logic                                          rst,
    input  dcache_bus_pkg::cpu_req_t                      stage_req_i,
    input  dcache_addr_pkg::way_sel_t                     way_hit_i,
    input  dcache_bus_pkg::tag_entry_t [`DCACHE_WAYS-1:0] way_entry_i,
    input  dcache_bus_pkg::line_t [`DCACHE_WAYS-1:0]      way_line_i,
    input  dcache_addr_pkg::way_idx_t                     victim_i,
    output logic                                          plru_update_o,
    output dcache_addr_pkg::way_sel_t                     plru_access_o,
    output dcache_addr_pkg::way_sel_t                     way_we_o,
    output dcache_addr_pkg::index_t                       wr_index_o,
    output dcache_bus_pkg::tag_entry_t                    wr_entry_o,
    output dcache_bus_pkg::line_t                         wr_line_o,
    output logic                                          ready_o,
    output dcache_bus_pkg::cpu_resp_t                     cpu_resp_o,
    output dcache_bus_pkg::mem_req_t                      mem_req_o,
    input  logic                                          mem_credit_i,
    input  dcache_bus_pkg::mem_resp_t                     mem_resp_i
);

    import dcache_addr_pkg::*;
    import dcache_bus_pkg::*;

    localparam int unsigned CREDIT_W = $clog2(`DCACHE_MEM_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`DCACHE_MEM_CREDITS);
    localparam index_t LAST_SET = index_t'(`DCACHE_SETS - 1);

    typedef enum logic [2:0] {
        INIT,
        LOOKUP,
        EVICT,
        REFILL_REQ,
        REFILL_WAIT
    } state_t;

    state_t state_q, state_d;
    index_t sweep_q;
    way_idx_t vway_q;
    logic [CREDIT_W-1:0] credit_q;
    logic has_credit;

    // last array write, the arrays still return old data for it
    way_sel_t last_we_q;
    index_t last_index_q;
    tag_entry_t last_entry_q;
    line_t last_line_q;

    index_t stage_index;
    tag_t stage_tag;
    offset_t stage_offset;
    tag_entry_t [`DCACHE_WAYS-1:0] fwd_entry;
    line_t [`DCACHE_WAYS-1:0] fwd_line;
    way_sel_t fwd_hit;
    line_t hit_line;
    line_t base_line;
    line_t new_line;
    word_t new_word;
    way_idx_t pick_way;
    logic lookup_miss;

    function automatic word_t merge_word(word_t old_w, word_t new_w, be_t be);
        word_t res;
        res = old_w;
        for (int b = 0; b < $bits(be_t); b++) begin
            if (be[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign stage_index = get_index(stage_req_i.addr);
    assign stage_tag = get_tag(stage_req_i.addr);
    assign stage_offset = get_offset(stage_req_i.addr);
    assign has_credit = (credit_q != '0);

    // per-way forwarding of last cycle's write, then the hit mux
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < `DCACHE_WAYS; i++) begin
            fwd_entry[i] = way_entry_i[i];
            fwd_line[i] = way_line_i[i];
            fwd_hit[i] = way_hit_i[i];
            if (last_we_q[i] && (last_index_q == stage_index)) begin
                fwd_entry[i] = last_entry_q;
                fwd_line[i] = last_line_q;
                fwd_hit[i] = last_entry_q.valid && (last_entry_q.tag == stage_tag);
            end
            if (fwd_hit[i]) begin
                hit_line = hit_line | fwd_line[i];
            end
        end
    end

    assign lookup_miss = stage_req_i.valid && !(|fwd_hit);

    // lowest invalid way wins over the plru victim
    always_comb begin
        pick_way = victim_i;
        for (int i = `DCACHE_WAYS - 1; i >= 0; i--) begin
            if (!fwd_entry[i].valid) begin
                pick_way = way_idx_t'(i);
            end
        end
    end

    // refill data or hit line, with the store merged in
    assign base_line = (state_q == REFILL_WAIT) ? mem_resp_i.data : hit_line;
    assign new_word = stage_req_i.write
        ? merge_word(base_line[stage_offset], stage_req_i.wdata, stage_req_i.be)
        : base_line[stage_offset];

    always_comb begin
        new_line = base_line;
        new_line[stage_offset] = new_word;
    end

    always_comb begin
        state_d = state_q;
        ready_o = 1'b0;
        cpu_resp_o = '{valid: 1'b0, rdata: new_word};
        mem_req_o = '0;
        way_we_o = '0;
        wr_index_o = stage_index;
        wr_entry_o = '{valid: 1'b1, dirty: stage_req_i.write, tag: stage_tag};
        wr_line_o = new_line;
        plru_update_o = 1'b0;
        plru_access_o = fwd_hit;
        case (state_q)
            INIT: begin
                // one set of every way per cycle
                way_we_o = '1;
                wr_index_o = sweep_q;
                wr_entry_o = '0;
                if (sweep_q == LAST_SET) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_miss) begin
                    if (fwd_entry[pick_way].valid && fwd_entry[pick_way].dirty) begin
                        state_d = EVICT;
                    end else begin
                        state_d = REFILL_REQ;
                    end
                end else begin
                    ready_o = 1'b1;
                    cpu_resp_o.valid = stage_req_i.valid;
                    plru_update_o = stage_req_i.valid;
                    if (stage_req_i.valid && stage_req_i.write) begin
                        way_we_o = fwd_hit;
                    end
                end
            end
            EVICT: begin
                if (has_credit) begin
                    mem_req_o.valid = 1'b1;
                    mem_req_o.write = 1'b1;
                    mem_req_o.label = '{tag: fwd_entry[vway_q].tag, index: stage_index};
                    mem_req_o.data = fwd_line[vway_q];
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (has_credit) begin
                    mem_req_o.valid = 1'b1;
                    mem_req_o.label = get_label(stage_req_i.addr);
                    state_d = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                if (mem_resp_i.valid) begin
                    // install, answer and take the next request together
                    ready_o = 1'b1;
                    cpu_resp_o.valid = 1'b1;
                    way_we_o = way_sel_t'(1) << vway_q;
                    plru_update_o = 1'b1;
                    plru_access_o = way_sel_t'(1) << vway_q;
                    state_d = LOOKUP;
                end
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= INIT;
            sweep_q <= '0;
            credit_q <= CREDIT_MAX;
            last_we_q <= '0;
        end else begin
            state_q <= state_d;
            last_we_q <= way_we_o;
            if (state_q == INIT) begin
                sweep_q <= sweep_q + 1'b1;
            end
            // send and return in one cycle cancel out
            if (mem_req_o.valid && !mem_credit_i) begin
                credit_q <= credit_q - 1'b1;
            end else if (!mem_req_o.valid && mem_credit_i) begin
                credit_q <= credit_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        last_index_q <= wr_index_o;
        last_entry_q <= wr_entry_o;
        last_line_q <= wr_line_o;
        if ((state_q == LOOKUP) && lookup_miss) begin
            vway_q <= pick_way;
        end
    end

endmodule

//--- rtl/dcache_top.sv
// data cache top level, connects lookup stage, ways, pseudo-LRU and controller
`include "dcache_settings.svh"

module dcache_top (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_bus_pkg::cpu_req_t  cpu_req_i,
    output logic                      ready_o,
    output dcache_bus_pkg::cpu_resp_t cpu_resp_o,
    output dcache_bus_pkg::mem_req_t  mem_req_o,
    input  logic                      mem_credit_i,
    input  dcache_bus_pkg::mem_resp_t mem_resp_i
);

    import dcache_addr_pkg::*;
    import dcache_bus_pkg::*;

    index_t rd_index;
    index_t stage_index;
    tag_t stage_tag;
    cpu_req_t stage_req;
    way_sel_t way_hit;
    way_sel_t way_we;
    tag_entry_t [`DCACHE_WAYS-1:0] way_entry;
    line_t [`DCACHE_WAYS-1:0] way_line;
    way_idx_t victim;
    logic plru_update;
    way_sel_t plru_access;
    index_t wr_index;
    tag_entry_t wr_entry;
    line_t wr_line;

    assign stage_index = get_index(stage_req.addr);
    assign stage_tag = get_tag(stage_req.addr);

    dcache_lookup u_lookup (
        .clk         (clk),
        .rst         (rst),
        .cpu_req_i   (cpu_req_i),
        .ready_i     (ready_o),
        .rd_index_o  (rd_index),
        .stage_req_o (stage_req)
    );

    for (genvar i = 0; i < `DCACHE_WAYS; i++) begin : gen_way
        dcache_way u_way (
            .clk          (clk),
            .rd_index_i   (rd_index),
            .lookup_tag_i (stage_tag),
            .we_i         (way_we[i]),
            .wr_index_i   (wr_index),
            .wr_entry_i   (wr_entry),
            .wr_line_i    (wr_line),
            .hit_o        (way_hit[i]),
            .entry_o      (way_entry[i]),
            .line_o       (way_line[i])
        );
    end

    dcache_plru u_plru (
        .clk      (clk),
        .rst      (rst),
        .index_i  (stage_index),
        .update_i (plru_update),
        .access_i (plru_access),
        .victim_o (victim)
    );

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .stage_req_i   (stage_req),
        .way_hit_i     (way_hit),
        .way_entry_i   (way_entry),
        .way_line_i    (way_line),
        .victim_i      (victim),
        .plru_update_o (plru_update),
        .plru_access_o (plru_access),
        .way_we_o      (way_we),
        .wr_index_o    (wr_index),
        .wr_entry_o    (wr_entry),
        .wr_line_o     (wr_line),
        .ready_o       (ready_o),
        .cpu_resp_o    (cpu_resp_o),
        .mem_req_o     (mem_req_o),
        .mem_credit_i  (mem_credit_i),
        .mem_resp_i    (mem_resp_i)
    );

endmodule

//--- test/dcache_mem_model.sv
// backing memory for the cache testbench, queues line requests and serves them after a delay
`include "dcache_settings.svh"

module dcache_mem_model #(
    parameter int unsigned MAX_DELAY = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  dcache_bus_pkg::mem_req_t  mem_req_i,
    output logic                      mem_credit_o,
    output dcache_bus_pkg::mem_resp_t mem_resp_o
);

    import dcache_addr_pkg::*;
    import dcache_bus_pkg::*;

    // only lines that were written back are stored
    line_t lines [label_t];
    mem_req_t req_q [$];
    int unsigned delay_cnt = 0;
    int unsigned credits_owed = 0;
    logic credit_q = 1'b0;
    mem_resp_t resp_q = '0;

    assign mem_credit_o = credit_q;
    assign mem_resp_o = resp_q;

    // initial contents, a hash of the whole word address
    function automatic word_t fill_word(addr_t addr);
        return (addr * 32'h9e37_79b1) ^ (addr >> 11) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic line_t read_line(label_t label);
        line_t line;
        if (lines.exists(label)) begin
            return lines[label];
        end
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            line[i] = fill_word({label, offset_t'(i), {BYTE_OFF_W{1'b0}}});
        end
        return line;
    endfunction

    always @(posedge clk) begin
        mem_req_t head;
        credit_q <= 1'b0;
        resp_q.valid <= 1'b0;
        if (rst) begin
            req_q.delete();
            delay_cnt = 0;
            credits_owed = 0;
        end else begin
            // serve in arrival order, so a writeback lands before a later refill
            if (req_q.size() != 0) begin
                if (delay_cnt == 0) begin
                    head = req_q.pop_front();
                    if (head.write) begin
                        lines[head.label] = head.data;
                    end else begin
                        resp_q <= '{valid: 1'b1, data: read_line(head.label)};
                    end
                    credits_owed++;
                    delay_cnt = $urandom_range(MAX_DELAY, 0);
                end else begin
                    delay_cnt--;
                end
            end
            // credits trickle back, so the cache sometimes runs dry
            if (credits_owed != 0 && $urandom_range(1, 0) == 1) begin
                credit_q <= 1'b1;
                credits_owed--;
            end
            if (mem_req_i.valid) begin
                req_q.push_back(mem_req_i);
            end
        end
    end

endmodule

//--- test/dcache_tb.sv
// top testbench of the sim build that checks the data cache against a shadow model
`include "dcache_settings.svh"

module dcache_tb;

    import dcache_addr_pkg::*;
    import dcache_bus_pkg::*;

    // about four times the longest expected run
    localparam int unsigned TIMEOUT_CYCLES = 20000;
    localparam int unsigned RANDOM_REQS = 2000;
    localparam int unsigned EVICT_LINES = `DCACHE_WAYS + 2;
    localparam index_t EVICT_SET = index_t'(9);

    logic clk = 1'b0;
    logic rst;
    cpu_req_t cpu_req;
    logic ready;
    cpu_resp_t cpu_resp;
    mem_req_t mem_req;
    logic mem_credit;
    mem_resp_t mem_resp;

    // expected value of every touched word
    word_t shadow [addr_t];
    word_t exp_q [$];
    string name_q [$];
    string test_name = "reset";
    int outstanding = 0;
    int unsigned cycle_count = 0;

    always #5 clk = ~clk;

    dcache_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .cpu_req_i    (cpu_req),
        .ready_o      (ready),
        .cpu_resp_o   (cpu_resp),
        .mem_req_o    (mem_req),
        .mem_credit_i (mem_credit),
        .mem_resp_i   (mem_resp)
    );

    dcache_mem_model u_mem (
        .clk          (clk),
        .rst          (rst),
        .mem_req_i    (mem_req),
        .mem_credit_o (mem_credit),
        .mem_resp_o   (mem_resp)
    );

    task automatic report_fail(string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // same hash the memory model starts from
    function automatic word_t fill_word(addr_t addr);
        return (addr * 32'h9e37_79b1) ^ (addr >> 11) ^ 32'h0f1e_2d3c;
    endfunction

    function automatic word_t shadow_word(addr_t addr);
        return shadow.exists(addr) ? shadow[addr] : fill_word(addr);
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, be_t be);
        word_t mask;
        for (int b = 0; b < $bits(be_t); b++) begin
            mask[8*b +: 8] = {8{be[b]}};
        end
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic addr_t make_addr(tag_t tag, index_t index, offset_t off);
        return {tag, index, off, {BYTE_OFF_W{1'b0}}};
    endfunction

    // holds the request until the cache takes it
    task automatic send_request(logic write, addr_t addr, word_t data, be_t be);
        cpu_req <= '{valid: 1'b1, write: write, addr: addr, wdata: data, be: be};
        do begin
            @(posedge clk);
        end while (!ready);
        cpu_req <= '0;
    endtask

    // response, handshake and credit checks on the values from before the edge
    always @(posedge clk) begin
        word_t exp_w;
        string exp_name;
        addr_t wb_addr;
        if (!rst) begin
            if (cpu_resp.valid) begin
                assert (exp_q.size() != 0)
                    else report_fail("response without a pending request");
                exp_w = exp_q.pop_front();
                exp_name = name_q.pop_front();
                assert (cpu_resp.rdata == exp_w)
                    else report_fail($sformatf("Fail %s: expected %h, actual %h",
                                               exp_name, exp_w, cpu_resp.rdata));
            end else begin
                assert (!(ready && exp_q.size() != 0))
                    else report_fail("ready_o high with a request pending but no response");
            end
            assert (!cpu_resp.valid || ready)
                else report_fail("response given while ready_o is low");
            if (cpu_req.valid && ready) begin
                exp_w = shadow_word(cpu_req.addr);
                if (cpu_req.write) begin
                    exp_w = merge_bytes(exp_w, cpu_req.wdata, cpu_req.be);
                    shadow[cpu_req.addr] = exp_w;
                end
                exp_q.push_back(exp_w);
                name_q.push_back(test_name);
            end
            if (mem_req.valid) begin
                assert (outstanding < `DCACHE_MEM_CREDITS)
                    else report_fail("memory request sent with no credit left");
                if (mem_req.write) begin
                    for (int i = 0; i < WORDS_PER_LINE; i++) begin
                        wb_addr = {mem_req.label, offset_t'(i), {BYTE_OFF_W{1'b0}}};
                        assert (mem_req.data[i] == shadow_word(wb_addr))
                            else report_fail($sformatf("Fail %s writeback %h: expected %h, actual %h",
                                                       test_name, wb_addr, shadow_word(wb_addr),
                                                       mem_req.data[i]));
                    end
                end
            end
            outstanding = outstanding + int'(mem_req.valid) - int'(mem_credit);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            report_fail($sformatf("timeout after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        int unsigned wait_cycles;
        addr_t addr;
        void'($urandom(28));
        rst <= 1'b1;
        cpu_req <= '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        // wait for the tag sweep to finish
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles == 1) begin
                assert (!ready && !cpu_resp.valid && !mem_req.valid)
                    else report_fail("outputs not idle after reset");
            end
        end while (!ready && wait_cycles < `DCACHE_SETS + 4);
        assert (ready)
            else report_fail("ready_o did not rise after the tag sweep");

        test_name <= "untouched";
        for (int i = 0; i < 4; i++) begin
            send_request(1'b0, make_addr(tag_t'('h100 + i), index_t'(3 * i), offset_t'(i)),
                         '0, '0);
        end

        // a read right after a write to the same line needs forwarding
        test_name <= "forward";
        addr = make_addr(tag_t'('h200), index_t'(7), offset_t'(1));
        send_request(1'b0, addr, '0, '0);
        send_request(1'b1, addr, 32'ha5a5_1234, 4'b0101);
        send_request(1'b0, addr, '0, '0);
        send_request(1'b1, addr + 4, 32'h1357_9bdf, 4'b1111);
        send_request(1'b0, addr + 4, '0, '0);
        send_request(1'b1, addr, 32'hcafe_f00d, 4'b1000);
        send_request(1'b1, addr, 32'h0bad_beef, 4'b0011);
        send_request(1'b0, addr, '0, '0);

        test_name <= "evict";
        for (int i = 0; i < EVICT_LINES; i++) begin
            send_request(1'b1, make_addr(tag_t'('h300 + i), EVICT_SET, offset_t'(i)),
                         $urandom(), 4'b1111);
        end
        for (int i = 0; i < EVICT_LINES; i++) begin
            send_request(1'b1, make_addr(tag_t'('h300 + i), EVICT_SET, offset_t'(0)),
                         $urandom(), 4'b0110);
        end
        for (int i = 0; i < EVICT_LINES; i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                send_request(1'b0, make_addr(tag_t'('h300 + i), EVICT_SET, offset_t'(w)),
                             '0, '0);
            end
        end

        // fresh lines in every set push the dirty ones out to memory
        test_name <= "sweep";
        for (int s = 0; s < `DCACHE_SETS; s++) begin
            for (int j = 0; j < `DCACHE_WAYS; j++) begin
                send_request(1'b0, make_addr(tag_t'('h400 + j), index_t'(s), '0), '0, '0);
            end
        end
        for (int i = 0; i < EVICT_LINES; i++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                send_request(1'b0, make_addr(tag_t'('h300 + i), EVICT_SET, offset_t'(w)),
                             '0, '0);
            end
        end
        send_request(1'b0, addr, '0, '0);
        send_request(1'b0, addr + 4, '0, '0);

        // few sets and many tags keep misses and evictions frequent
        test_name <= "random";
        for (int n = 0; n < RANDOM_REQS; n++) begin
            addr = make_addr(tag_t'('h500 + $urandom_range(5, 0)),
                             index_t'($urandom_range(3, 1)),
                             offset_t'($urandom_range(3, 0)));
            send_request($urandom_range(1, 0) == 1, addr, $urandom(),
                         be_t'($urandom_range(15, 0)));
            if ($urandom_range(7, 0) == 0) begin
                @(posedge clk);
            end
        end

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // one more cycle so a stray response is still caught
        @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/dcache_addr_pkg.sv
rtl/dcache_bus_pkg.sv
rtl/dcache_lookup.sv
rtl/dcache_way.sv
rtl/dcache_plru.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= dcache_tb
RTL_TOP    ?= dcache_top
FILELIST   ?= sources.f
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := ALL TESTS PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
